// ==== Bender.yml ====
package:
  name: accel_cfg

sources:
  - hdl/accel_cfg_pkg.sv
  - hdl/cfg_write_sequencer.sv
  - hdl/write_req_fifo.sv
  - hdl/axil_write_master.sv
  - hdl/accel_cfg_top.sv
  - target: test
    files:
      - verification/accel_cfg_tb.sv

// ==== hdl/accel_cfg_pkg.sv ====
// Accelerator configuration sequencer shared constants, register map and types
package accel_cfg_pkg;

    // Register map
    localparam logic [12:0] CONTROL_OFFSET    = 13'h000;
    localparam logic [12:0] IRQ_EN_OFFSET     = 13'h004;
    localparam logic [12:0] IRQ_STATUS_OFFSET = 13'h00C;
    localparam logic [12:0] CON_BASE          = 13'h100;
    localparam logic [12:0] ACT_BASE          = 13'h200;
    localparam logic [12:0] WEI_BASE          = 13'h300;
    localparam logic [12:0] OUT_BASE          = 13'h400;

    localparam int N_REGS_CON  = 4;
    localparam int N_REGS_ACT  = 4;
    localparam int N_REGS_WEI  = 3;
    localparam int N_REGS_OUT  = 3;
    localparam int N_CFG_REGS  = N_REGS_CON + N_REGS_ACT + N_REGS_WEI + N_REGS_OUT;
    localparam int N_IRQ_EN    = 3;
    // Index 0 holds the control bits, config values follow
    localparam int N_CTRL_REGS = N_CFG_REGS + 1;

    // Host control register 0
    localparam int BIT_KEEP_A     = 19;
    localparam int BIT_KEEP_B     = 20;
    localparam int BIT_KEEP_C     = 21;
    localparam int BIT_SKIP_START = 22;

    // Accelerator control word
    localparam int CW_START  = 0;
    localparam int CW_ENABLE = 1;
    localparam int CW_SWAP   = 16;
    localparam int CW_KEEP_A = 17;
    localparam int CW_KEEP_B = 18;
    localparam int CW_KEEP_C = 19;

    localparam int ADDR_W     = 13;
    localparam int DATA_W     = 32;
    localparam int AXI_ADDR_W = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int IDX_W      = $clog2(N_CTRL_REGS);
    localparam int FIFO_DEPTH = 4;

    typedef logic [N_CTRL_REGS-1:0][DATA_W-1:0] ctrl_regs_t;

    typedef enum logic [2:0] {
        IDLE, LOAD, SEND_CFG, DRAIN_CFG, SEND_START, WAIT_ACC, SEND_CLR, DRAIN_END
    } seq_state_t;

    typedef enum logic [2:0] {CON, ACT, WEI, OUT, IRQ} cfg_region_t;

endpackage

// ==== hdl/accel_cfg_top.sv ====
// Accelerator configuration sequencer top level with AXI4-Lite write port
`timescale 1ns/1ps

module accel_cfg_top import accel_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fsm_start,
    input  ctrl_regs_t            ctrl_regs,
    input  logic                  irq_in,
    output logic                  fsm_done,
    output logic                  fwd_irq,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [AXI_ADDR_W-1:0] awaddr,
    output logic                  wvalid,
    input  logic                  wready,
    output logic [DATA_W-1:0]     wdata,
    output logic [STRB_W-1:0]     wstrb,
    input  logic                  bvalid,
    output logic                  bready
);

    logic              push;
    logic [ADDR_W-1:0] push_addr;
    logic [DATA_W-1:0] push_data;
    logic              full;
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_data;
    logic              pop;
    logic              bus_idle;

    cfg_write_sequencer seq_i (
        .clk       (clk),
        .rst       (rst),
        .fsm_start (fsm_start),
        .ctrl_regs (ctrl_regs),
        .irq_in    (irq_in),
        .full      (full),
        .bus_idle  (bus_idle),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data),
        .fsm_done  (fsm_done),
        .fwd_irq   (fwd_irq)
    );

    write_req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data),
        .pop       (pop),
        .full      (full),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_data  (req_data)
    );

    axil_write_master master_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .pop       (pop),
        .bus_idle  (bus_idle),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bready    (bready)
    );

endmodule

// ==== hdl/axil_write_master.sv ====
// AXI4-Lite write master issuing one queued request at a time on AW, W and B
`timescale 1ns/1ps

module axil_write_master import accel_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [ADDR_W-1:0]     req_addr,
    input  logic [DATA_W-1:0]     req_data,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  pop,
    output logic                  bus_idle,
    output logic                  awvalid,
    output logic [AXI_ADDR_W-1:0] awaddr,
    output logic                  wvalid,
    output logic [DATA_W-1:0]     wdata,
    output logic [STRB_W-1:0]     wstrb,
    output logic                  bready
);

    logic              busy;
    logic              aw_done;
    logic              w_done;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;

    // Head is taken as soon as the previous response is back
    assign pop      = req_valid && !busy;
    assign bus_idle = !req_valid && !busy;

    assign awvalid = busy && !aw_done;
    assign awaddr  = {{(AXI_ADDR_W - ADDR_W){1'b0}}, addr_q};
    assign wvalid  = busy && !w_done;
    assign wdata   = data_q;
    assign wstrb   = '1;
    assign bready  = busy && aw_done && w_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (pop) begin
            busy    <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (busy) begin
            // AW and W may be accepted in either order
            if (awvalid && awready) begin
                aw_done <= 1'b1;
            end
            if (wvalid && wready) begin
                w_done <= 1'b1;
            end
            if (bready && bvalid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            addr_q <= req_addr;
            data_q <= req_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)));

endmodule

// ==== hdl/cfg_write_sequencer.sv ====
// Configuration sequencer that walks the register map and queues write requests
`timescale 1ns/1ps

module cfg_write_sequencer import accel_cfg_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fsm_start,
    input  ctrl_regs_t        ctrl_regs,
    input  logic              irq_in,
    input  logic              full,
    input  logic              bus_idle,
    output logic              push,
    output logic [ADDR_W-1:0] push_addr,
    output logic [DATA_W-1:0] push_data,
    output logic              fsm_done,
    output logic              fwd_irq
);

    seq_state_t        state;
    cfg_region_t       region;
    logic [ADDR_W-1:0] cfg_addr;
    logic [IDX_W-1:0]  remain;
    logic [IDX_W-1:0]  reg_idx;
    logic              skip_start;
    logic              keep_a;
    logic              keep_b;
    logic              keep_c;
    logic [DATA_W-1:0] ctrl_word;
    logic              accepted;

    assign push     = state inside {SEND_CFG, SEND_START, SEND_CLR};
    assign accepted = push && !full;

    // Accelerator interrupt is masked while a run is in progress
    assign fwd_irq = (state == IDLE) && irq_in;

    always_comb begin
        ctrl_word            = '0;
        ctrl_word[CW_START]  = !skip_start;
        ctrl_word[CW_ENABLE] = 1'b1;
        ctrl_word[CW_SWAP]   = 1'b1;
        ctrl_word[CW_KEEP_A] = keep_a;
        ctrl_word[CW_KEEP_B] = keep_b;
        ctrl_word[CW_KEEP_C] = keep_c;
    end

    always_comb begin
        case (state)
            SEND_CFG: begin
                push_addr = cfg_addr;
                push_data = (region == IRQ) ? DATA_W'(1) : ctrl_regs[reg_idx + 1'b1];
            end
            SEND_START: begin
                push_addr = CONTROL_OFFSET;
                push_data = ctrl_word;
            end
            // Interrupt clear
            default: begin
                push_addr = IRQ_STATUS_OFFSET;
                push_data = DATA_W'(1);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            fsm_done <= 1'b0;
        end else begin
            fsm_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (fsm_start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    skip_start <= ctrl_regs[0][BIT_SKIP_START];
                    keep_a     <= ctrl_regs[0][BIT_KEEP_A];
                    keep_b     <= ctrl_regs[0][BIT_KEEP_B];
                    keep_c     <= ctrl_regs[0][BIT_KEEP_C];
                    region     <= CON;
                    cfg_addr   <= CON_BASE;
                    remain     <= IDX_W'(N_REGS_CON - 1);
                    reg_idx    <= '0;
                    state      <= SEND_CFG;
                end
                SEND_CFG: begin
                    if (accepted) begin
                        reg_idx <= reg_idx + 1'b1;
                        if (remain == '0) begin
                            case (region)
                                CON: begin
                                    region   <= ACT;
                                    cfg_addr <= ACT_BASE;
                                    remain   <= IDX_W'(N_REGS_ACT - 1);
                                end
                                ACT: begin
                                    region   <= WEI;
                                    cfg_addr <= WEI_BASE;
                                    remain   <= IDX_W'(N_REGS_WEI - 1);
                                end
                                WEI: begin
                                    region   <= OUT;
                                    cfg_addr <= OUT_BASE;
                                    remain   <= IDX_W'(N_REGS_OUT - 1);
                                end
                                OUT: begin
                                    region   <= IRQ;
                                    cfg_addr <= IRQ_EN_OFFSET;
                                    remain   <= IDX_W'(N_IRQ_EN - 1);
                                end
                                default: begin
                                    state <= DRAIN_CFG;
                                end
                            endcase
                        end else begin
                            cfg_addr <= cfg_addr + ADDR_W'(4);
                            remain   <= remain - 1'b1;
                        end
                    end
                end
                // All config responses must be back before the start write
                DRAIN_CFG: begin
                    if (bus_idle) begin
                        state <= SEND_START;
                    end
                end
                SEND_START: begin
                    if (accepted) begin
                        state <= skip_start ? DRAIN_END : WAIT_ACC;
                    end
                end
                WAIT_ACC: begin
                    if (irq_in) begin
                        state <= SEND_CLR;
                    end
                end
                SEND_CLR: begin
                    if (accepted) begin
                        state <= DRAIN_END;
                    end
                end
                DRAIN_END: begin
                    if (bus_idle) begin
                        state    <= IDLE;
                        fsm_done <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Start write only goes out onto an idle bus
    assert property (@(posedge clk) disable iff (rst) (state == SEND_START) |-> bus_idle);

endmodule

// ==== hdl/write_req_fifo.sv ====
// Request FIFO holding pending address/data writes between sequencer and bus master
`timescale 1ns/1ps

module write_req_fifo import accel_cfg_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [ADDR_W-1:0] push_addr,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic              full,
    output logic              req_valid,
    output logic [ADDR_W-1:0] req_addr,
    output logic [DATA_W-1:0] req_data
);

    logic [ADDR_W-1:0]            addr_mem [DEPTH];
    logic [DATA_W-1:0]            data_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign full      = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign req_valid = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && req_valid;

    // Head entry is shown directly
    assign req_addr = addr_mem[rd_ptr];
    assign req_data = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    // A request refused while full must be offered again unchanged
    assert property (@(posedge clk) disable iff (rst)
        (push && full) |=> (push && $stable(push_addr) && $stable(push_data)));

    assert property (@(posedge clk) disable iff (rst) pop |-> req_valid);

endmodule

// ==== sources.f ====
hdl/accel_cfg_pkg.sv
hdl/cfg_write_sequencer.sv
hdl/write_req_fifo.sv
hdl/axil_write_master.sv
hdl/accel_cfg_top.sv
verification/accel_cfg_tb.sv

// ==== verification/accel_cfg_tb.sv ====
// Directed testbench for the configuration sequencer with an AXI4-Lite slave model
`timescale 1ns/1ps

module accel_cfg_tb import accel_cfg_pkg::*; ();

    localparam int IRQ_DELAY  = 6;
    localparam int RUN_WRITES = N_CFG_REGS + N_IRQ_EN + 2;
    // Three runs with a loose per-write budget for random stalls, plus reset and idle checks
    localparam int MAX_CYCLES = 3 * (RUN_WRITES * 12 + IRQ_DELAY + 20) + 50;

    logic                  clk;
    logic                  rst;
    logic                  fsm_start;
    ctrl_regs_t            ctrl_regs;
    logic                  irq_in;
    logic                  fsm_done;
    logic                  fwd_irq;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic                  bvalid;
    logic                  bready;

    logic [31:0] lfsr = 32'h74f4e8c8;
    logic [3:0]  rnd;
    logic        bp;
    logic        aw_got;
    logic        w_got;
    logic [31:0] got_addr;
    logic [31:0] got_data;
    int          bdelay;
    int          irq_timer;
    int          cycles = 0;
    int          mismatches;
    int          failures;
    string       cur_test = "idle";
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];

    accel_cfg_top dut_i (.*);

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
        mismatches++;
    endtask

    // Slave model decides everything on the falling edge for the next rising edge
    always @(negedge clk) begin
        for (int b = 0; b < 4; b++) begin
            rnd[b] = next_bit();
        end
        if (rst) begin
            awready   = 1'b0;
            wready    = 1'b0;
            bvalid    = 1'b0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            bdelay    = 0;
            irq_timer = 0;
            irq_in    = 1'b0;
        end else begin
            awready = bp ? rnd[0] : 1'b1;
            wready  = bp ? rnd[1] : 1'b1;
            if (irq_timer != 0) begin
                irq_timer--;
                if (irq_timer == 0) begin
                    irq_in = 1'b1;
                end
            end
            if (bvalid) begin
                // Response taken on the last rising edge
                bvalid = 1'b0;
                aw_got = 1'b0;
                w_got  = 1'b0;
                log_addr.push_back(got_addr);
                log_data.push_back(got_data);
                if (got_addr == 32'(CONTROL_OFFSET) && got_data[CW_START]) begin
                    irq_timer = IRQ_DELAY;
                end
                if (got_addr == 32'(IRQ_STATUS_OFFSET)) begin
                    irq_in = 1'b0;
                end
            end else if (aw_got && w_got) begin
                if (bready !== 1'b1) begin
                    $display("%s: bready is low after AW and W were accepted", cur_test);
                    failures++;
                end
                if (bdelay == 0) begin
                    bvalid = 1'b1;
                end else begin
                    bdelay--;
                end
            end else begin
                if (bready !== 1'b0) begin
                    $display("%s: bready is high before AW and W were both accepted",
                             cur_test);
                    failures++;
                end
                if (awvalid && awready) begin
                    aw_got   = 1'b1;
                    got_addr = awaddr;
                end
                if (wvalid && wready) begin
                    w_got    = 1'b1;
                    got_data = wdata;
                    if (wstrb !== {STRB_W{1'b1}}) begin
                        report_mismatch(cur_test, "wstrb", {STRB_W{1'b1}}, wstrb);
                    end
                end
                bdelay = bp ? int'(rnd[3:2]) : 0;
            end
        end
    end

    task automatic run_sequence(input string name, input logic skip, input logic bp_on,
                                input logic [2:0] keep);
        logic [ADDR_W-1:0] bases [5];
        int                sizes [5];
        logic [31:0]       exp_addr [$];
        logic [31:0]       exp_data [$];
        logic [31:0]       cw;
        int                idx;
        int                lat;
        bases    = '{CON_BASE, ACT_BASE, WEI_BASE, OUT_BASE, IRQ_EN_OFFSET};
        sizes    = '{N_REGS_CON, N_REGS_ACT, N_REGS_WEI, N_REGS_OUT, N_IRQ_EN};
        idx      = 0;
        bp       = bp_on;
        cur_test = name;
        log_addr.delete();
        log_data.delete();
        for (int i = 1; i < N_CTRL_REGS; i++) begin
            ctrl_regs[i] = 32'(i) * 32'h0103_0507 ^ 32'h5ac3_0f96;
        end
        ctrl_regs[0]                 = 32'h0000_0f0f;
        ctrl_regs[0][BIT_KEEP_A]     = keep[0];
        ctrl_regs[0][BIT_KEEP_B]     = keep[1];
        ctrl_regs[0][BIT_KEEP_C]     = keep[2];
        ctrl_regs[0][BIT_SKIP_START] = skip;
        // Regions in map order; the last region is the interrupt enables
        for (int r = 0; r < 5; r++) begin
            for (int k = 0; k < sizes[r]; k++) begin
                exp_addr.push_back(32'(bases[r]) + 32'(4 * k));
                if (r == 4) begin
                    exp_data.push_back(32'd1);
                end else begin
                    idx++;
                    exp_data.push_back(ctrl_regs[idx]);
                end
            end
        end
        cw            = '0;
        cw[CW_START]  = !skip;
        cw[CW_ENABLE] = 1'b1;
        cw[CW_SWAP]   = 1'b1;
        cw[CW_KEEP_A] = keep[0];
        cw[CW_KEEP_B] = keep[1];
        cw[CW_KEEP_C] = keep[2];
        exp_addr.push_back(32'(CONTROL_OFFSET));
        exp_data.push_back(cw);
        if (!skip) begin
            exp_addr.push_back(32'(IRQ_STATUS_OFFSET));
            exp_data.push_back(32'd1);
        end

        fsm_start = 1'b1;
        @(negedge clk);
        fsm_start = 1'b0;
        lat = 0;
        // Load, push and head register take one cycle each
        while (!awvalid) begin
            @(negedge clk);
            lat++;
        end
        if (lat != 3) begin
            report_mismatch(name, "start to awvalid cycles", 3, lat);
        end
        while (!fsm_done) begin
            if (fwd_irq) begin
                $display("%s: fwd_irq is high while the sequencer is busy", name);
                failures++;
            end
            @(negedge clk);
        end
        @(negedge clk);
        if (fsm_done) begin
            $display("%s: fsm_done stayed high for more than one cycle", name);
            failures++;
        end

        if (log_addr.size() != exp_addr.size()) begin
            report_mismatch(name, "write count", exp_addr.size(), log_addr.size());
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (log_addr[i] !== exp_addr[i]) begin
                    report_mismatch(name, $sformatf("address %0d", i), exp_addr[i], log_addr[i]);
                end
                if (log_data[i] !== exp_data[i]) begin
                    report_mismatch(name, $sformatf("data %0d", i), exp_data[i], log_data[i]);
                end
            end
        end
    endtask

    task automatic check_irq_forwarding();
        cur_test = "irq_forward";
        irq_in   = 1'b1;
        @(negedge clk);
        if (fwd_irq !== 1'b1) begin
            report_mismatch("irq_forward", "fwd_irq while idle", 1, fwd_irq);
        end
        irq_in = 1'b0;
        @(negedge clk);
        if (fwd_irq !== 1'b0) begin
            report_mismatch("irq_forward", "fwd_irq after release", 0, fwd_irq);
        end
    endtask

    always @(negedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fsm_start  = 1'b0;
        ctrl_regs  = '0;
        irq_in     = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bp         = 1'b0;
        mismatches = 0;
        failures   = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        run_sequence("cfg_ready", 1'b0, 1'b0, 3'b101);
        run_sequence("cfg_backpressure", 1'b0, 1'b1, 3'b101);
        run_sequence("skip_start", 1'b1, 1'b1, 3'b010);
        check_irq_forwarding();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
